// File: rtl/rename_pkg.sv
// ========================================
// Sizes, index types and backout states for the rename stage
// Compiled first. The RTL and the testbench refer to its contents
// by scoped names
// ========================================

package rename_pkg;

	// ========================================
	// Sizes
	// ========================================

	// Reorder buffer slots
	localparam int ROB_ENTRIES = 16;
	// Architectural and physical register files
	localparam int AREGS = 32;
	localparam int PREGS = 64;
	// Largest instruction group that dispatch may form
	localparam int GROUP_SIZE = 4;
	// Group numbers wrap at this width
	localparam int GRP_BITS = 4;

	localparam int ROB_NDX_BITS = $clog2(ROB_ENTRIES);
	// The live count needs one more value than an index to show a full ROB
	localparam int ROB_CNT_BITS = $clog2(ROB_ENTRIES + 1);

	// ========================================
	// Types
	// ========================================

	typedef logic [ROB_NDX_BITS-1:0] rob_ndx_t;
	typedef logic [ROB_CNT_BITS-1:0] rob_cnt_t;
	typedef logic [$clog2(AREGS)-1:0] aregno_t;
	typedef logic [$clog2(PREGS)-1:0] pregno_t;
	typedef logic [GRP_BITS-1:0] grp_t;

	// Backout walk states
	typedef enum logic [1:0] {IDLE = 2'd0, BACK = 2'd1, FWD = 2'd2} bo_state_t;

endpackage

// File: rtl/rob_store.sv
// ========================================
// Reorder buffer entry store for the rename stage
// Accepts dispatches at tail, retires at head and cuts the tail
// back to just after a mispredicted branch. The read port serves
// the backout walk
// ========================================

`timescale 1ns/1ps

module rob_store (
	input logic clk,
	input logic rst,
	input logic dispatch,
	input logic dispatch_grp_end,
	input logic retire,
	input logic mispredict,
	input logic stall,
	input rename_pkg::aregno_t dispatch_areg,
	input rename_pkg::pregno_t dispatch_nreg,
	input rename_pkg::pregno_t alloc_preg,
	input rename_pkg::rob_ndx_t fcu_id,
	input rename_pkg::rob_ndx_t rd_ndx,
	output logic alloc_wr,
	output rename_pkg::aregno_t alloc_areg,
	output rename_pkg::pregno_t alloc_nreg,
	output rename_pkg::rob_ndx_t tail,
	output rename_pkg::grp_t ent_grp [rename_pkg::ROB_ENTRIES],
	output rename_pkg::aregno_t rd_areg,
	output rename_pkg::pregno_t rd_preg,
	output rename_pkg::pregno_t rd_nreg,
	output logic full
);

	// Per entry payload
	rename_pkg::aregno_t ent_areg [rename_pkg::ROB_ENTRIES];
	rename_pkg::pregno_t ent_preg [rename_pkg::ROB_ENTRIES];
	rename_pkg::pregno_t ent_nreg [rename_pkg::ROB_ENTRIES];

	rename_pkg::rob_ndx_t head;
	rename_pkg::rob_cnt_t count;
	rename_pkg::rob_cnt_t cut_count;
	rename_pkg::grp_t cur_grp;
	logic accept;
	logic retire_ok;

	assign full = (count == rename_pkg::rob_cnt_t'(rename_pkg::ROB_ENTRIES));

	// The one place where a dispatch is judged acceptable
	assign accept = dispatch & ~mispredict & ~stall & ~full;
	assign retire_ok = retire & (count != '0);

	// Rename request to the map. The old mapping returns on alloc_preg in the same cycle
	assign alloc_wr = accept;
	assign alloc_areg = dispatch_areg;
	assign alloc_nreg = dispatch_nreg;

	// Entries from head up to and including the branch stay live after a cut.
	// This is 1 to 16 and never 0 since the branch itself is live
	assign cut_count = rename_pkg::rob_cnt_t'(rename_pkg::rob_ndx_t'(fcu_id - head))
		+ rename_pkg::rob_cnt_t'(1) - rename_pkg::rob_cnt_t'(retire_ok);

	// ========================================
	// Pointers, count and group numbering
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			cur_grp <= '0;
		end else begin
			if (retire_ok)
				head <= head + rename_pkg::rob_ndx_t'(1);
			if (mispredict) begin
				tail <= fcu_id + rename_pkg::rob_ndx_t'(1);
				count <= cut_count;
				// Whatever follows the branch opens a fresh group
				cur_grp <= ent_grp[fcu_id] + rename_pkg::grp_t'(1);
			end else begin
				if (accept) begin
					tail <= tail + rename_pkg::rob_ndx_t'(1);
					if (dispatch_grp_end)
						cur_grp <= cur_grp + rename_pkg::grp_t'(1);
				end
				count <= count + rename_pkg::rob_cnt_t'(accept)
					- rename_pkg::rob_cnt_t'(retire_ok);
			end
		end
	end

	// Group numbers start at all ones so that a slot not yet written since
	// reset never matches one of the first groups in the group start search
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rename_pkg::ROB_ENTRIES; i++)
				ent_grp[i] <= '1;
		end else if (accept) begin
			ent_grp[tail] <= cur_grp;
		end
	end

	// Payload of the entry at tail
	always_ff @(posedge clk) begin
		if (accept) begin
			ent_areg[tail] <= dispatch_areg;
			ent_preg[tail] <= alloc_preg;
			ent_nreg[tail] <= dispatch_nreg;
		end
	end

	// Read port for the backout walk
	assign rd_areg = ent_areg[rd_ndx];
	assign rd_preg = ent_preg[rd_ndx];
	assign rd_nreg = ent_nreg[rd_ndx];

endmodule

// File: rtl/rename_map.sv
// ========================================
// Register alias table of the rename stage
// One rename write from dispatch and one repair write from the
// backout machine. Both reads are combinational
// ========================================

`timescale 1ns/1ps

module rename_map (
	input logic clk,
	input logic rst,
	input logic alloc_wr,
	input logic bo_wr,
	input rename_pkg::aregno_t alloc_areg,
	input rename_pkg::aregno_t bo_areg,
	input rename_pkg::aregno_t lookup_areg,
	input rename_pkg::pregno_t alloc_nreg,
	input rename_pkg::pregno_t bo_preg,
	output rename_pkg::pregno_t alloc_preg,
	output rename_pkg::pregno_t lookup_preg
);

	// One physical register per architectural register
	rename_pkg::pregno_t map [rename_pkg::AREGS];

	// ========================================
	// Table update
	// ========================================

	// After reset every architectural register r sits in physical register r.
	// A repair write wins over a rename write. Dispatch is refused while the
	// backout stalls so the two never meet in practice
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rename_pkg::AREGS; i++)
				map[i] <= rename_pkg::pregno_t'(i);
		end else if (bo_wr) begin
			map[bo_areg] <= bo_preg;
		end else if (alloc_wr) begin
			map[alloc_areg] <= alloc_nreg;
		end
	end

	// ========================================
	// Read ports
	// ========================================

	// Old mapping of the destination being renamed.
	// The ROB keeps it so that a backout can put it back
	assign alloc_preg = map[alloc_areg];

	// Lookup for source operands. Shows the repaired table once stall falls
	assign lookup_preg = map[lookup_areg];

endmodule

// File: rtl/rat_backout_fsm.sv
// ========================================
// Backout machine that repairs the alias table after a mispredict
// Walks back from the youngest entry to the branch restoring old
// mappings, then forward from the group start to the branch
// writing new ones. Stall covers the whole repair
// ========================================

`timescale 1ns/1ps

module rat_backout_fsm (
	input logic clk,
	input logic rst,
	input logic mispredict,
	input rename_pkg::rob_ndx_t fcu_id,
	input rename_pkg::rob_ndx_t tail,
	input rename_pkg::grp_t ent_grp [rename_pkg::ROB_ENTRIES],
	input rename_pkg::aregno_t rd_areg,
	input rename_pkg::pregno_t rd_preg,
	input rename_pkg::pregno_t rd_nreg,
	output rename_pkg::rob_ndx_t rd_ndx,
	output logic bo_wr,
	output rename_pkg::aregno_t bo_areg,
	output rename_pkg::pregno_t bo_preg,
	output logic stall
);

	rename_pkg::bo_state_t state;
	// Entry being visited
	rename_pkg::rob_ndx_t backout_id;
	// Branch index held for the whole repair
	rename_pkg::rob_ndx_t branch_id;
	// Oldest entry of the branch's own group
	rename_pkg::rob_ndx_t grp_start;
	logic visit_back;
	logic visit_fwd;

	// The store is read at the visited entry
	assign rd_ndx = backout_id;

	// A backward visit happens on every BACK cycle short of the branch.
	// The cycle that reaches the branch only searches for the group start
	assign visit_back = (state == rename_pkg::BACK) && (backout_id != branch_id);
	assign visit_fwd = (state == rename_pkg::FWD);

	// ========================================
	// Group start search
	// ========================================

	// Looks up to GROUP_SIZE-1 entries behind the branch.
	// The loop runs nearest first so the furthest match is the one that stays.
	// Group numbers of neighbours differ by at most one, so members of the
	// group always form a run ending at the branch
	always_comb begin
		grp_start = branch_id;
		for (int j = 1; j < rename_pkg::GROUP_SIZE; j++) begin
			if (ent_grp[branch_id - rename_pkg::rob_ndx_t'(j)] == ent_grp[branch_id])
				grp_start = branch_id - rename_pkg::rob_ndx_t'(j);
		end
	end

	// ========================================
	// Walk control
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rename_pkg::IDLE;
			backout_id <= '0;
		end else begin
			case (state)
				rename_pkg::IDLE: begin
					// The tail seen here is the one before the cut,
					// so tail-1 is the youngest entry
					if (mispredict) begin
						backout_id <= tail - rename_pkg::rob_ndx_t'(1);
						state <= rename_pkg::BACK;
					end
				end
				rename_pkg::BACK: begin
					if (backout_id != branch_id) begin
						backout_id <= backout_id - rename_pkg::rob_ndx_t'(1);
					end else begin
						backout_id <= grp_start;
						state <= rename_pkg::FWD;
					end
				end
				rename_pkg::FWD: begin
					// The branch itself is the last forward visit
					if (backout_id != branch_id)
						backout_id <= backout_id + rename_pkg::rob_ndx_t'(1);
					else
						state <= rename_pkg::IDLE;
				end
				default: begin
					state <= rename_pkg::IDLE;
				end
			endcase
		end
	end

	// Branch index is taken only when a new repair starts
	always_ff @(posedge clk) begin
		if (state == rename_pkg::IDLE && mispredict)
			branch_id <= fcu_id;
	end

	// ========================================
	// Repair writes
	// ========================================

	// One write per visited entry, issued the cycle after the visit
	always_ff @(posedge clk) begin
		if (rst)
			bo_wr <= 1'b0;
		else
			bo_wr <= visit_back | visit_fwd;
	end

	// Younger entries give back their old mapping and group members
	// up to the branch put their own mapping in again
	always_ff @(posedge clk) begin
		if (visit_back | visit_fwd) begin
			bo_areg <= rd_areg;
			bo_preg <= visit_back ? rd_preg : rd_nreg;
		end
	end

	// Held until the last repair write has reached the table
	assign stall = mispredict | (state != rename_pkg::IDLE) | bo_wr;

endmodule

// File: rtl/rename_backout_top.sv
// ========================================
// Rename stage top level
// Joins the ROB store, the alias table and the backout machine.
// Dispatch, retire and mispredict come in as plain strobes
// ========================================

`timescale 1ns/1ps

module rename_backout_top (
	input logic clk,
	input logic rst,
	input logic dispatch,
	input rename_pkg::aregno_t dispatch_areg,
	input rename_pkg::pregno_t dispatch_nreg,
	input logic dispatch_grp_end,
	input logic retire,
	input logic mispredict,
	input rename_pkg::rob_ndx_t fcu_id,
	input rename_pkg::aregno_t lookup_areg,
	output rename_pkg::pregno_t lookup_preg,
	output logic stall,
	output logic full
);

	// Rename request from the store to the table
	logic alloc_wr;
	rename_pkg::aregno_t alloc_areg;
	rename_pkg::pregno_t alloc_nreg;
	rename_pkg::pregno_t alloc_preg;

	// Store state seen by the backout machine
	rename_pkg::rob_ndx_t tail;
	rename_pkg::grp_t ent_grp [rename_pkg::ROB_ENTRIES];

	// Backout read port into the store
	rename_pkg::rob_ndx_t rd_ndx;
	rename_pkg::aregno_t rd_areg;
	rename_pkg::pregno_t rd_preg;
	rename_pkg::pregno_t rd_nreg;

	// Repair writes into the table
	logic bo_wr;
	rename_pkg::aregno_t bo_areg;
	rename_pkg::pregno_t bo_preg;

	rob_store u_rob_store (
		.clk(clk),
		.rst(rst),
		.dispatch(dispatch),
		.dispatch_grp_end(dispatch_grp_end),
		.retire(retire),
		.mispredict(mispredict),
		.stall(stall),
		.dispatch_areg(dispatch_areg),
		.dispatch_nreg(dispatch_nreg),
		.alloc_preg(alloc_preg),
		.fcu_id(fcu_id),
		.rd_ndx(rd_ndx),
		.alloc_wr(alloc_wr),
		.alloc_areg(alloc_areg),
		.alloc_nreg(alloc_nreg),
		.tail(tail),
		.ent_grp(ent_grp),
		.rd_areg(rd_areg),
		.rd_preg(rd_preg),
		.rd_nreg(rd_nreg),
		.full(full)
	);

	rename_map u_rename_map (
		.clk(clk),
		.rst(rst),
		.alloc_wr(alloc_wr),
		.bo_wr(bo_wr),
		.alloc_areg(alloc_areg),
		.bo_areg(bo_areg),
		.lookup_areg(lookup_areg),
		.alloc_nreg(alloc_nreg),
		.bo_preg(bo_preg),
		.alloc_preg(alloc_preg),
		.lookup_preg(lookup_preg)
	);

	rat_backout_fsm u_rat_backout_fsm (
		.clk(clk),
		.rst(rst),
		.mispredict(mispredict),
		.fcu_id(fcu_id),
		.tail(tail),
		.ent_grp(ent_grp),
		.rd_areg(rd_areg),
		.rd_preg(rd_preg),
		.rd_nreg(rd_nreg),
		.rd_ndx(rd_ndx),
		.bo_wr(bo_wr),
		.bo_areg(bo_areg),
		.bo_preg(bo_preg),
		.stall(stall)
	);

endmodule

// File: testbench/rename_backout_props.sv
// ========================================
// Concurrent assertions on the backout machine
// Bound into every rat_backout_fsm instance at the end of this file
// ========================================

`timescale 1ns/1ps

module rename_backout_props (
	input logic clk,
	input logic rst,
	input rename_pkg::bo_state_t state,
	input logic bo_wr,
	input logic stall
);

	// Cycles spent outside IDLE in the current repair
	int busy_cycles;

	always_ff @(posedge clk) begin
		if (rst)
			busy_cycles <= 0;
		else if (state == rename_pkg::IDLE)
			busy_cycles <= 0;
		else
			busy_cycles <= busy_cycles + 1;
	end

	// ========================================
	// Properties
	// ========================================

	// A repair write in IDLE can only be the one left over from the last FWD visit
	a_bo_wr_idle: assert property (@(posedge clk) disable iff (rst)
		(state == rename_pkg::IDLE && bo_wr) |-> ($past(state) == rename_pkg::FWD))
		else $error("repair write in IDLE without a forward visit just before");

	// Dispatch must be held off for the whole walk and for the repair write
	// that trails the last visit
	a_stall_busy: assert property (@(posedge clk) disable iff (rst)
		(state != rename_pkg::IDLE) |=> stall)
		else $error("stall low while the backout machine is busy");

	// Longest walk is one lap of the ROB plus a group, well under two laps
	a_walk_bound: assert property (@(posedge clk) disable iff (rst)
		busy_cycles <= 2 * rename_pkg::ROB_ENTRIES)
		else $error("backout machine did not return to IDLE in time");

endmodule

bind rat_backout_fsm rename_backout_props u_props (
	.clk(clk),
	.rst(rst),
	.state(state),
	.bo_wr(bo_wr),
	.stall(stall)
);

// File: testbench/tb_rename_backout.sv
// ========================================
// Testbench for the rename stage with mispredict backout
// Random dispatch, retire, mispredict and lookup traffic from a fixed
// seed, checked against a model alias table and a model ROB queue
// ========================================

`timescale 1ns/1ps

module tb_rename_backout;

	localparam int RESET_CYCLES = 8;
	localparam int NUM_OPS = 400;
	// Extra operations for the directed fill at the end
	localparam int TOTAL_OPS = NUM_OPS + 32;
	localparam int CYCLE_LIMIT = TOTAL_OPS * 20 + RESET_CYCLES;

	logic clk = 1'b0;
	logic rst;
	logic dispatch;
	rename_pkg::aregno_t dispatch_areg;
	rename_pkg::pregno_t dispatch_nreg;
	logic dispatch_grp_end;
	logic retire;
	logic mispredict;
	rename_pkg::rob_ndx_t fcu_id;
	rename_pkg::aregno_t lookup_areg;
	rename_pkg::pregno_t lookup_preg;
	logic stall;
	logic full;

	integer seed = 32'h880f;
	logic [31:0] rnd;
	int cycles = 0;
	int error_count = 0;

	// ========================================
	// Reference model
	// ========================================

	// Speculative map as the lookup port should show it
	rename_pkg::pregno_t model_rat [rename_pkg::AREGS];
	// Map built from retired entries only
	rename_pkg::pregno_t base_rat [rename_pkg::AREGS];
	// Live ROB entries, oldest at the front
	rename_pkg::aregno_t q_areg [$];
	rename_pkg::pregno_t q_nreg [$];
	rename_pkg::rob_ndx_t model_head;
	// Instructions so far in the open group
	int grp_cnt;

	rename_backout_top u_dut (
		.clk(clk),
		.rst(rst),
		.dispatch(dispatch),
		.dispatch_areg(dispatch_areg),
		.dispatch_nreg(dispatch_nreg),
		.dispatch_grp_end(dispatch_grp_end),
		.retire(retire),
		.mispredict(mispredict),
		.fcu_id(fcu_id),
		.lookup_areg(lookup_areg),
		.lookup_preg(lookup_preg),
		.stall(stall),
		.full(full)
	);

	always #4 clk = ~clk;

	// Run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic verify_full();
		check_value("full", 32'(full), 32'(q_areg.size() == rename_pkg::ROB_ENTRIES));
	endtask

	// Walks all registers through the lookup port within one clock period
	task automatic compare_map();
		for (int r = 0; r < rename_pkg::AREGS; r++) begin
			lookup_areg = rename_pkg::aregno_t'(r);
			#0.15;
			check_value($sformatf("lookup_preg[%0d]", r), 32'(lookup_preg),
				32'(model_rat[r]));
		end
	endtask

	// After a cut the map is the retired map with every live entry replayed in order
	function automatic void rebuild_model();
		for (int r = 0; r < rename_pkg::AREGS; r++)
			model_rat[r] = base_rat[r];
		for (int i = 0; i < q_areg.size(); i++)
			model_rat[q_areg[i]] = q_nreg[i];
	endfunction

	// ========================================
	// Operations
	// ========================================

	// A dispatch while full is lost, so the lookup must keep the old value
	task automatic send_dispatch();
		rename_pkg::aregno_t a;
		rename_pkg::pregno_t n;
		logic take;
		logic grp_end;
		next_cycle();
		rnd = $random(seed);
		a = rnd[4:0];
		n = rnd[10:5];
		// Groups close by chance and always at GROUP_SIZE
		grp_end = (grp_cnt == rename_pkg::GROUP_SIZE - 1) || (rnd[12:11] == 2'd0);
		take = ~stall & ~full;
		dispatch = 1'b1;
		dispatch_areg = a;
		dispatch_nreg = n;
		dispatch_grp_end = grp_end;
		lookup_areg = a;
		next_cycle();
		dispatch = 1'b0;
		dispatch_grp_end = 1'b0;
		if (take) begin
			model_rat[a] = n;
			q_areg.push_back(a);
			q_nreg.push_back(n);
			grp_cnt = grp_end ? 0 : grp_cnt + 1;
		end
		#2;
		check_value("lookup_preg", 32'(lookup_preg), 32'(model_rat[a]));
		verify_full();
	endtask

	// Retire on an empty ROB is also driven and must do nothing
	task automatic pulse_retire();
		logic go;
		next_cycle();
		go = (q_areg.size() != 0);
		retire = 1'b1;
		next_cycle();
		retire = 1'b0;
		if (go) begin
			base_rat[q_areg[0]] = q_nreg[0];
			void'(q_areg.pop_front());
			void'(q_nreg.pop_front());
			model_head = model_head + rename_pkg::rob_ndx_t'(1);
		end
		#2;
		verify_full();
	endtask

	task automatic raise_mispredict(input logic youngest);
		int pick;
		next_cycle();
		if (q_areg.size() != 0 && !stall) begin
			rnd = $random(seed);
			// A quarter of the branches are the youngest entry
			if (youngest || rnd[1:0] == 2'd0)
				pick = q_areg.size() - 1;
			else
				pick = int'(rnd[17:2]) % q_areg.size();
			fcu_id = model_head + rename_pkg::rob_ndx_t'(pick);
			mispredict = 1'b1;
			// A dispatch held up through the mispredict and the repair is lost
			rnd = $random(seed);
			dispatch = 1'b1;
			dispatch_areg = rnd[4:0];
			dispatch_nreg = rnd[10:5];
			#1;
			check_value("stall", 32'(stall), 32'd1);
			next_cycle();
			mispredict = 1'b0;
			while (q_areg.size() > pick + 1) begin
				void'(q_areg.pop_back());
				void'(q_nreg.pop_back());
			end
			grp_cnt = 0;
			rebuild_model();
			// Repair length depends on the younger entries and the group position
			while (stall)
				next_cycle();
			dispatch = 1'b0;
			verify_full();
			compare_map();
		end
	endtask

	task automatic probe_lookup();
		next_cycle();
		rnd = $random(seed);
		lookup_areg = rnd[4:0];
		#2;
		check_value("lookup_preg", 32'(lookup_preg), 32'(model_rat[rnd[4:0]]));
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		rst = 1'b1;
		dispatch = 1'b0;
		dispatch_areg = '0;
		dispatch_nreg = '0;
		dispatch_grp_end = 1'b0;
		retire = 1'b0;
		mispredict = 1'b0;
		fcu_id = '0;
		lookup_areg = '0;
		for (int r = 0; r < rename_pkg::AREGS; r++) begin
			model_rat[r] = rename_pkg::pregno_t'(r);
			base_rat[r] = rename_pkg::pregno_t'(r);
		end
		model_head = '0;
		grp_cnt = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// Identity map and quiet status out of reset
		check_value("stall", 32'(stall), 32'd0);
		check_value("full", 32'(full), 32'd0);
		compare_map();

		// Random mix, weighted toward dispatch so the ROB fills up
		for (int i = 0; i < NUM_OPS; i++) begin
			rnd = $random(seed);
			if (rnd[3:0] < 4'd8)
				send_dispatch();
			else if (rnd[3:0] < 4'd11)
				pulse_retire();
			else if (rnd[3:0] < 4'd13)
				raise_mispredict(1'b0);
			else
				probe_lookup();
		end

		// Fill the ROB, push one more while full, then back out from the youngest
		while (q_areg.size() < rename_pkg::ROB_ENTRIES)
			send_dispatch();
		send_dispatch();
		raise_mispredict(1'b1);

		if (error_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "checks failed");
		end
	end

endmodule

// File: sim.f
rtl/rename_pkg.sv
rtl/rob_store.sv
rtl/rename_map.sv
rtl/rat_backout_fsm.sv
rtl/rename_backout_top.sv
testbench/rename_backout_props.sv
testbench/tb_rename_backout.sv

// File: Makefile
# Verilator build and run of the rename stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_rename_backout -f sim.f
	./obj_dir/Vtb_rename_backout

clean:
	rm -rf obj_dir
